// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w   = 4;

    localparam logic [id_w-1:0] fetch_id = 4'd0;
    localparam logic [id_w-1:0] lsu_id   = 4'd1;

    localparam logic [1:0] burst_incr = 2'b01;
    localparam logic [1:0] resp_okay  = 2'b00;

    typedef enum logic [1:0] {
        op_nop   = 2'b00,
        op_load  = 2'b01,
        op_store = 2'b10,
        op_halt  = 2'b11
    } op_e;

    // value doubles as the AXI size code
    typedef enum logic [1:0] {
        sz_byte = 2'b00,
        sz_half = 2'b01,
        sz_word = 2'b10
    } size_e;

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t; // same layout for reads

    typedef struct packed {
        logic [data_w-1:0]   data;
        logic [data_w/8-1:0] strb;
        logic                last;
    } axi_w_t;

    typedef struct packed {
        logic [id_w-1:0] id;
        logic [1:0]      resp;
    } axi_b_t;

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [data_w-1:0] inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic [addr_w-1:0] pc;
        op_e               op;
        size_e             size;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } mem_op_t;

    typedef struct packed {
        logic                write;
        logic [addr_w-1:0]   addr;
        size_e               size;
        logic [data_w-1:0]   wdata;
        logic [data_w/8-1:0] wstrb;
    } bus_req_t;

    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } ld_result_t;

endpackage

`default_nettype wire

// File: fetch_unit.sv
`default_nettype none

module fetch_unit import mem_pkg::*; #(
    parameter logic [addr_w-1:0] reset_pc = 32'h0000_0000
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              halted,
    output logic              fetch_valid,
    output fetch_pkt_t        fetch_pkt,
    input  logic              fetch_ready,
    output logic              req_valid,
    output bus_req_t          req,
    input  logic              req_ready,
    input  logic              rsp_valid,
    input  logic [data_w-1:0] rsp_data
);

    logic [addr_w-1:0] pc;
    logic              pending; // read issued, answer not back yet
    logic              fetch_fire;

    assign fetch_fire = fetch_valid && fetch_ready;

    assign req = '{write: 1'b0, addr: pc, size: sz_word, wdata: '0, wstrb: '0};

    always_ff @(posedge clock) begin
        if (reset) begin
            pc          <= reset_pc;
            pending     <= 1'b0;
            req_valid   <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            if (req_valid && req_ready) begin
                req_valid <= 1'b0;
                pending   <= 1'b1;
            end else if (!req_valid && !pending && !halted && (!fetch_valid || fetch_fire)) begin
                req_valid <= 1'b1; // next word as soon as the buffer frees up
            end
            if (rsp_valid) begin
                pending <= 1'b0;
                if (!halted) begin
                    fetch_valid <= 1'b1;
                end
            end
            if (fetch_fire) begin
                fetch_valid <= 1'b0;
                pc          <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rsp_valid && !halted) begin
            fetch_pkt <= '{pc: pc, inst: rsp_data};
        end
    end

endmodule

`default_nettype wire

// File: inst_decoder.sv
`default_nettype none

module inst_decoder import mem_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       in_valid,
    input  fetch_pkt_t in_pkt,
    output logic       in_ready,
    output logic       out_valid,
    output mem_op_t    out_op,
    input  logic       out_ready,
    output logic       halted
);

    mem_op_t dec;
    logic    in_fire;

    // nothing more is taken once halted
    assign in_ready = !halted && (!out_valid || out_ready);
    assign in_fire  = in_valid && in_ready;

    always_comb begin
        dec.pc    = in_pkt.pc;
        dec.op    = op_e'(in_pkt.inst[31:30]);
        dec.size  = size_e'(in_pkt.inst[29:28]);
        dec.addr  = {20'b0, in_pkt.inst[27:16]};
        dec.wdata = {16'b0, in_pkt.inst[15:0]};
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
            halted    <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (in_fire && (dec.op == op_load || dec.op == op_store)) begin
                out_valid <= 1'b1;
            end
            if (in_fire && dec.op == op_halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in_fire && (dec.op == op_load || dec.op == op_store)) begin
            out_op <= dec;
        end
    end

endmodule

`default_nettype wire

// File: load_store_unit.sv
`default_nettype none

module load_store_unit import mem_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic              op_valid,
    input  mem_op_t           op,
    output logic              op_ready,
    output logic              req_valid,
    output bus_req_t          req,
    input  logic              req_ready,
    input  logic              rsp_valid,
    input  logic [data_w-1:0] rsp_data,
    output logic              load_valid,
    output ld_result_t        load_result,
    input  logic              load_ready
);

    mem_op_t             cur;
    logic                busy;
    logic [1:0]          byte_off;
    logic [addr_w-1:0]   bus_addr;
    logic [data_w-1:0]   lane_data;
    logic [data_w-1:0]   load_mask;
    logic [data_w/8-1:0] strb;
    logic                is_store;

    assign op_ready = !busy && !load_valid; // result slot must be free
    assign is_store = (cur.op == op_store);

    // misaligned accesses are aligned down to their size
    always_comb begin
        case (cur.size)
            sz_byte: begin
                byte_off  = cur.addr[1:0];
                bus_addr  = cur.addr;
                lane_data = {4{cur.wdata[7:0]}};
                load_mask = 32'h0000_00ff;
                strb      = 4'b0001 << byte_off;
            end
            sz_half: begin
                byte_off  = {cur.addr[1], 1'b0};
                bus_addr  = {cur.addr[addr_w-1:1], 1'b0};
                lane_data = {2{cur.wdata[15:0]}};
                load_mask = 32'h0000_ffff;
                strb      = 4'b0011 << byte_off;
            end
            default: begin
                byte_off  = 2'd0;
                bus_addr  = {cur.addr[addr_w-1:2], 2'b00};
                lane_data = cur.wdata;
                load_mask = 32'hffff_ffff;
                strb      = 4'b1111;
            end
        endcase
    end

    assign req = '{write: is_store, addr: bus_addr, size: cur.size,
                   wdata: lane_data, wstrb: is_store ? strb : 4'b0000};

    always_ff @(posedge clock) begin
        if (reset) begin
            busy       <= 1'b0;
            req_valid  <= 1'b0;
            load_valid <= 1'b0;
        end else begin
            if (op_valid && op_ready) begin
                busy      <= 1'b1;
                req_valid <= 1'b1;
            end
            if (req_valid && req_ready) begin
                req_valid <= 1'b0;
            end
            if (rsp_valid) begin
                busy <= 1'b0;
                if (!is_store) begin
                    load_valid <= 1'b1;
                end
            end
            if (load_valid && load_ready) begin
                load_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (op_valid && op_ready) begin
            cur <= op;
        end
        if (rsp_valid && !is_store) begin
            load_result <= '{pc: cur.pc, addr: cur.addr,
                             data: (rsp_data >> {byte_off, 3'b000}) & load_mask};
        end
    end

endmodule

`default_nettype wire

// File: axi_bus_arbiter.sv
`default_nettype none

module axi_bus_arbiter import mem_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic              fetch_req_valid,
    input  bus_req_t          fetch_req,
    output logic              fetch_req_ready,
    output logic              fetch_rsp_valid,
    output logic [data_w-1:0] fetch_rsp_data,
    input  logic              lsu_req_valid,
    input  bus_req_t          lsu_req,
    output logic              lsu_req_ready,
    output logic              lsu_rsp_valid,
    output logic [data_w-1:0] lsu_rsp_data,
    output logic              awvalid,
    input  logic              awready,
    output axi_aw_t           aw,
    output logic              wvalid,
    input  logic              wready,
    output axi_w_t            w,
    input  logic              bvalid,
    output logic              bready,
    input  axi_b_t            b,
    output logic              arvalid,
    input  logic              arready,
    output axi_ar_t           ar,
    input  logic              rvalid,
    output logic              rready,
    input  axi_r_t            r,
    output logic              err
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,  // AR, or AW with W alongside
        st_wdata, // AW taken, W still pending
        st_resp
    } state_e;

    state_e            state;
    bus_req_t          cur;
    logic [id_w-1:0]   cur_id;
    logic              w_done;
    logic [data_w-1:0] rsp_data;
    logic              aw_fire;
    logic              w_fire;
    logic              ar_fire;
    logic              resp_fire;
    logic              resp_bad;

    // load-store wins a tie, its operation is older
    assign lsu_req_ready   = (state == st_idle);
    assign fetch_req_ready = (state == st_idle) && !lsu_req_valid;

    assign awvalid = (state == st_addr) && cur.write;
    assign wvalid  = cur.write && ((state == st_addr && !w_done) || state == st_wdata);
    assign arvalid = (state == st_addr) && !cur.write;
    assign bready  = (state == st_resp) && cur.write;
    assign rready  = (state == st_resp) && !cur.write;

    assign aw = '{id: cur_id, addr: cur.addr, len: 8'd0, size: {1'b0, cur.size},
                  burst: burst_incr};
    assign ar = '{id: cur_id, addr: cur.addr, len: 8'd0, size: {1'b0, cur.size},
                  burst: burst_incr};
    assign w  = '{data: cur.wdata, strb: cur.wstrb, last: 1'b1};

    assign aw_fire   = awvalid && awready;
    assign w_fire    = wvalid && wready;
    assign ar_fire   = arvalid && arready;
    assign resp_fire = (bvalid && bready) || (rvalid && rready);
    // a wrong id counts as an error too
    assign resp_bad  = cur.write ? (b.resp != resp_okay || b.id != cur_id)
                                 : (r.resp != resp_okay || r.id != cur_id);

    assign fetch_rsp_data = rsp_data;
    assign lsu_rsp_data   = rsp_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            state           <= st_idle;
            w_done          <= 1'b0;
            err             <= 1'b0;
            fetch_rsp_valid <= 1'b0;
            lsu_rsp_valid   <= 1'b0;
        end else begin
            fetch_rsp_valid <= 1'b0;
            lsu_rsp_valid   <= 1'b0;
            case (state)
                st_idle: begin
                    w_done <= 1'b0;
                    if (lsu_req_valid || fetch_req_valid) begin
                        state <= st_addr;
                    end
                end
                st_addr: begin
                    if (w_fire) begin
                        w_done <= 1'b1;
                    end
                    if (ar_fire || (aw_fire && (w_done || w_fire))) begin
                        state <= st_resp;
                    end else if (aw_fire) begin
                        state <= st_wdata;
                    end
                end
                st_wdata: begin
                    if (w_fire) begin
                        state <= st_resp;
                    end
                end
                default: begin
                    if (resp_fire) begin
                        state           <= st_idle;
                        err             <= err | resp_bad;
                        fetch_rsp_valid <= (cur_id == fetch_id);
                        lsu_rsp_valid   <= (cur_id == lsu_id);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_idle) begin
            cur    <= lsu_req_valid ? lsu_req : fetch_req;
            cur_id <= lsu_req_valid ? lsu_id : fetch_id;
        end
        if (state == st_resp && resp_fire) begin
            rsp_data <= cur.write ? '0 : r.data;
        end
    end

endmodule

`default_nettype wire

// File: mem_sys_top.sv
`default_nettype none

module mem_sys_top import mem_pkg::*; #(
    parameter logic [addr_w-1:0] reset_pc = 32'h0000_0000
) (
    input  logic       clock,
    input  logic       reset,
    output logic       awvalid,
    input  logic       awready,
    output axi_aw_t    aw,
    output logic       wvalid,
    input  logic       wready,
    output axi_w_t     w,
    input  logic       bvalid,
    output logic       bready,
    input  axi_b_t     b,
    output logic       arvalid,
    input  logic       arready,
    output axi_ar_t    ar,
    input  logic       rvalid,
    output logic       rready,
    input  axi_r_t     r,
    output logic       load_valid,
    output ld_result_t load_result,
    input  logic       load_ready,
    output logic       halted,
    output logic       err
);

    fetch_pkt_t        fetch_pkt;
    mem_op_t           op;
    bus_req_t          fetch_req;
    bus_req_t          lsu_req;
    logic              fetch_valid;
    logic              fetch_ready;
    logic              op_valid;
    logic              op_ready;
    logic              fetch_req_valid;
    logic              fetch_req_ready;
    logic              fetch_rsp_valid;
    logic              lsu_req_valid;
    logic              lsu_req_ready;
    logic              lsu_rsp_valid;
    logic [data_w-1:0] fetch_rsp_data;
    logic [data_w-1:0] lsu_rsp_data;

    fetch_unit #(.reset_pc(reset_pc)) fetch_unit_inst (
        .clock(clock), .reset(reset), .halted(halted),
        .fetch_valid(fetch_valid), .fetch_pkt(fetch_pkt), .fetch_ready(fetch_ready),
        .req_valid(fetch_req_valid), .req(fetch_req), .req_ready(fetch_req_ready),
        .rsp_valid(fetch_rsp_valid), .rsp_data(fetch_rsp_data)
    );

    inst_decoder inst_decoder_inst (
        .clock(clock), .reset(reset),
        .in_valid(fetch_valid), .in_pkt(fetch_pkt), .in_ready(fetch_ready),
        .out_valid(op_valid), .out_op(op), .out_ready(op_ready),
        .halted(halted)
    );

    load_store_unit load_store_unit_inst (
        .clock(clock), .reset(reset),
        .op_valid(op_valid), .op(op), .op_ready(op_ready),
        .req_valid(lsu_req_valid), .req(lsu_req), .req_ready(lsu_req_ready),
        .rsp_valid(lsu_rsp_valid), .rsp_data(lsu_rsp_data),
        .load_valid(load_valid), .load_result(load_result), .load_ready(load_ready)
    );

    axi_bus_arbiter axi_bus_arbiter_inst (
        .clock(clock), .reset(reset),
        .fetch_req_valid(fetch_req_valid), .fetch_req(fetch_req),
        .fetch_req_ready(fetch_req_ready),
        .fetch_rsp_valid(fetch_rsp_valid), .fetch_rsp_data(fetch_rsp_data),
        .lsu_req_valid(lsu_req_valid), .lsu_req(lsu_req), .lsu_req_ready(lsu_req_ready),
        .lsu_rsp_valid(lsu_rsp_valid), .lsu_rsp_data(lsu_rsp_data),
        .awvalid(awvalid), .awready(awready), .aw(aw),
        .wvalid(wvalid), .wready(wready), .w(w),
        .bvalid(bvalid), .bready(bready), .b(b),
        .arvalid(arvalid), .arready(arready), .ar(ar),
        .rvalid(rvalid), .rready(rready), .r(r),
        .err(err)
    );

endmodule

`default_nettype wire

// File: axi_mem_model.sv
`default_nettype none

module axi_mem_model import mem_pkg::*; (
    input  logic    clock,
    input  logic    awvalid,
    output logic    awready,
    input  axi_aw_t aw,
    input  logic    wvalid,
    output logic    wready,
    input  axi_w_t  w,
    output logic    bvalid,
    input  logic    bready,
    output axi_b_t  b,
    input  logic    arvalid,
    output logic    arready,
    input  axi_ar_t ar,
    output logic    rvalid,
    input  logic    rready,
    output axi_r_t  r
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [0:16383]; // 64 KB, word indexed
    logic        busy;
    axi_aw_t     aw_q;
    axi_w_t      w_q;
    axi_ar_t     ar_q;

    // 0xf00 to 0xfff answers with SLVERR
    function automatic logic in_err_window(logic [31:0] a);
        return (a[31:12] == 20'h0) && (a[11:8] == 4'hf);
    endfunction

    initial begin
        awready = 1'b0;
        wready  = 1'b0;
        arready = 1'b0;
        bvalid  = 1'b0;
        rvalid  = 1'b0;
        b       = '0;
        r       = '0;
        busy    = 1'b0;
        forever begin
            @(negedge clock);
            if (arvalid) begin
                busy = 1'b1;
                repeat ($urandom % 4) @(negedge clock);
                ar_q    = ar;
                arready = 1'b1;
                @(negedge clock);
                arready = 1'b0;
                repeat ($urandom % 4) @(negedge clock);
                r = '{id: ar_q.id, data: mem[ar_q.addr[15:2]], last: 1'b1,
                      resp: in_err_window(ar_q.addr) ? 2'b10 : resp_okay};
                rvalid = 1'b1;
                while (!rready) @(negedge clock);
                @(negedge clock);
                rvalid = 1'b0;
                busy   = 1'b0;
            end else if (awvalid) begin
                busy = 1'b1;
                fork
                    begin
                        repeat ($urandom % 4) @(negedge clock);
                        aw_q    = aw;
                        awready = 1'b1;
                        @(negedge clock);
                        awready = 1'b0;
                    end
                    begin
                        repeat ($urandom % 4) @(negedge clock);
                        w_q    = w;
                        wready = 1'b1;
                        @(negedge clock);
                        wready = 1'b0;
                    end
                join
                if (!in_err_window(aw_q.addr)) begin
                    for (int i = 0; i < 4; i++) begin
                        if (w_q.strb[i]) mem[aw_q.addr[15:2]][i*8 +: 8] = w_q.data[i*8 +: 8];
                    end
                end
                repeat ($urandom % 4) @(negedge clock);
                b = '{id: aw_q.id, resp: in_err_window(aw_q.addr) ? 2'b10 : resp_okay};
                bvalid = 1'b1;
                while (!bready) @(negedge clock);
                @(negedge clock);
                bvalid = 1'b0;
                busy   = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: mem_sys_assert.sv
`default_nettype none

module mem_sys_assert import mem_pkg::*; (
    input logic    clock,
    input logic    reset,
    input logic    arvalid,
    input logic    arready,
    input axi_ar_t ar,
    input logic    awvalid,
    input logic    awready,
    input axi_aw_t aw,
    input logic    wvalid,
    input logic    wready,
    input axi_w_t  w,
    input logic    rready
);
    timeunit 1ns;
    timeprecision 100ps;

    ar_hold: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("AR valid or payload changed before arready");

    aw_hold: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("AW valid or payload changed before awready");

    w_hold: assert property (@(posedge clock) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("W valid or payload changed before wready");

    // one read at a time, address phase is over before data phase
    ar_vs_r: assert property (@(posedge clock) disable iff (reset) !(arvalid && rready))
        else $error("arvalid high while rready high");

endmodule

bind mem_sys_top mem_sys_assert mem_sys_assert_inst (.*);

`default_nettype wire

// File: tb_mem_sys.sv
`default_nettype none

module tb_mem_sys import mem_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] reset_pc = 32'h0000_8000;
    localparam int          pc_base  = reset_pc >> 2;
    localparam int          num_tests = 5;
    localparam int          cycle_limit = 400 * num_tests;

    logic       clock = 1'b0;
    logic       reset;
    logic       awvalid, awready, wvalid, wready, bvalid, bready;
    logic       arvalid, arready, rvalid, rready;
    axi_aw_t    aw;
    axi_w_t     w;
    axi_b_t     b;
    axi_ar_t    ar;
    axi_r_t     r;
    logic       load_valid;
    ld_result_t load_result;
    logic       load_ready;
    logic       halted;
    logic       err;

    logic [31:0] shadow [0:1023]; // expected data area 0x000..0xfff
    logic [31:0] prog [$];
    int          cycles = 0;

    mem_sys_top #(.reset_pc(reset_pc)) mem_sys_top_inst (.*);

    axi_mem_model mem_model (
        .clock(clock),
        .awvalid(awvalid), .awready(awready), .aw(aw),
        .wvalid(wvalid), .wready(wready), .w(w),
        .bvalid(bvalid), .bready(bready), .b(b),
        .arvalid(arvalid), .arready(arready), .ar(ar),
        .rvalid(rvalid), .rready(rready), .r(r)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic fail_value(string name, logic [127:0] got, logic [127:0] exp);
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        $display("TESTBENCH FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic check_load(string name, ld_result_t got, ld_result_t exp);
        if (got !== exp) fail_value(name, got, exp);
    endtask

    task automatic check_word(string name, logic [data_w-1:0] got, logic [data_w-1:0] exp);
        if (got !== exp) fail_value(name, got, exp);
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) fail_value(name, got, exp);
    endtask

    // single-beat INCR with the owning requester's id
    task automatic check_ax(string name, axi_ar_t got, logic [id_w-1:0] exp_id);
        if ({got.id, got.len, got.burst} !== {exp_id, 8'd0, burst_incr}) begin
            fail_value(name, {got.id, got.len, got.burst}, {exp_id, 8'd0, burst_incr});
        end
    endtask

    // fetches read the program area, data accesses stay below 0x1000
    always @(negedge clock) begin
        if (!reset && arvalid) check_ax("ar", ar, (ar.addr >= reset_pc) ? fetch_id : lsu_id);
        if (!reset && awvalid) check_ax("aw", aw, lsu_id);
        if (!reset && wvalid) check_bit("w.last", w.last, 1'b1);
    end

    function automatic logic [31:0] encode(op_e op, size_e sz, logic [11:0] a, logic [15:0] d);
        return {op, sz, a, d};
    endfunction

    // store data lands in the lanes picked by size and the low address bits
    task automatic shadow_store(size_e sz, logic [11:0] a, logic [15:0] d);
        int idx;
        idx = a[11:2];
        case (sz)
            sz_byte: shadow[idx][a[1:0]*8 +: 8] = d[7:0];
            sz_half: shadow[idx][a[1]*16 +: 16] = d;
            default: shadow[idx] = {16'h0, d};
        endcase
    endtask

    function automatic logic [31:0] shadow_load(size_e sz, logic [11:0] a);
        logic [31:0] word;
        word = shadow[a[11:2]];
        case (sz)
            sz_byte: return {24'h0, word[a[1:0]*8 +: 8]};
            sz_half: return {16'h0, word[a[1]*16 +: 16]};
            default: return word;
        endcase
    endfunction

    // runs prog plus a closing load and halt and checks loads, memory and err
    task automatic run_program(input bit random_ready, input logic expect_err);
        ld_result_t exp_q [$];
        ld_result_t exp_ld;
        logic [31:0] code [$];
        logic [31:0] inst;
        bit          stopped;
        int          quiet;
        code = prog;
        code.push_back(encode(op_load, sz_word, 12'h000, 16'h0));
        code.push_back(encode(op_halt, sz_word, 12'h000, 16'h0));
        reset      = 1'b1;
        load_ready = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            mem_model.mem[i] = 32'h0;
            shadow[i]        = 32'h0;
        end
        for (int i = 0; i < 256; i++) mem_model.mem[pc_base + i] = 32'h0; // no-ops
        stopped = 1'b0;
        for (int k = 0; k < code.size(); k++) begin
            inst = code[k];
            mem_model.mem[pc_base + k] = inst;
            if (!stopped) begin
                case (op_e'(inst[31:30]))
                    op_halt:  stopped = 1'b1;
                    op_store: shadow_store(size_e'(inst[29:28]), inst[27:16], inst[15:0]);
                    op_load: begin
                        exp_ld.pc   = reset_pc + 4 * k;
                        exp_ld.addr = {20'h0, inst[27:16]};
                        exp_ld.data = shadow_load(size_e'(inst[29:28]), inst[27:16]);
                        exp_q.push_back(exp_ld);
                    end
                    default: ;
                endcase
            end
        end
        repeat (16) @(negedge clock);
        reset = 1'b0;
        check_bit("err", err, 1'b0);
        check_bit("halted", halted, 1'b0);
        while (!(halted && exp_q.size() == 0)) begin
            @(negedge clock);
            load_ready = random_ready ? 1'($urandom % 2) : 1'b1;
            if (load_valid && load_ready) begin
                if (exp_q.size() == 0) begin
                    $display("a load result came out with no load left to expect");
                    $display("TESTBENCH FAILED");
                    $fatal(1, "extra load");
                end else begin
                    check_load("load_result", load_result, exp_q.pop_front());
                end
            end
        end
        quiet = 0;
        while (quiet < 4) begin
            @(negedge clock);
            quiet = (mem_model.busy || arvalid || awvalid) ? 0 : quiet + 1;
        end
        check_bit("load_valid", load_valid, 1'b0);
        check_bit("err", err, expect_err);
        for (int i = 0; i < 1024; i++) begin
            check_word($sformatf("mem[%03h]", i * 4), mem_model.mem[i], shadow[i]);
        end
    endtask

    task automatic word_store_load();
        logic [11:0] addrs [4] = '{12'h000, 12'h004, 12'h080, 12'h3fc};
        prog.delete();
        foreach (addrs[i]) prog.push_back(encode(op_store, sz_word, addrs[i], 16'ha5c0 + i));
        foreach (addrs[i]) prog.push_back(encode(op_load, sz_word, addrs[i], 16'h0));
        run_program(1'b0, 1'b0);
    endtask

    task automatic sizes_and_lanes();
        prog.delete();
        for (int i = 0; i < 4; i++) begin
            prog.push_back(encode(op_store, sz_byte, 12'h040 + i, 16'h0011 * (i + 1)));
        end
        prog.push_back(encode(op_store, sz_half, 12'h048, 16'hbeef));
        prog.push_back(encode(op_store, sz_half, 12'h04e, 16'hcafe));
        prog.push_back(encode(op_store, sz_half, 12'h051, 16'h1234)); // aligned down
        for (int i = 0; i < 4; i++) prog.push_back(encode(op_load, sz_byte, 12'h040 + i, 16'h0));
        prog.push_back(encode(op_load, sz_half, 12'h04a, 16'h0));
        prog.push_back(encode(op_load, sz_half, 12'h04e, 16'h0));
        prog.push_back(encode(op_load, sz_byte, 12'h049, 16'h0));
        prog.push_back(encode(op_load, sz_word, 12'h050, 16'h0));
        run_program(1'b0, 1'b0);
    endtask

    task automatic back_pressure();
        op_e op;
        prog.delete();
        for (int i = 0; i < 20; i++) begin
            op = ($urandom % 2) ? op_load : op_store;
            prog.push_back(encode(op, size_e'($urandom % 3), 12'($urandom % 256),
                                  16'($urandom)));
        end
        run_program(1'b1, 1'b0);
    endtask

    task automatic halt_stops_fetch();
        prog.delete();
        prog.push_back(encode(op_store, sz_word, 12'h100, 16'h7777));
        prog.push_back(encode(op_load, sz_word, 12'h100, 16'h0));
        prog.push_back(encode(op_halt, sz_word, 12'h000, 16'h0));
        prog.push_back(encode(op_store, sz_word, 12'h104, 16'h9999));
        prog.push_back(encode(op_load, sz_word, 12'h100, 16'h0));
        run_program(1'b0, 1'b0);
        repeat (20) begin
            @(negedge clock);
            check_bit("arvalid", arvalid, 1'b0);
        end
        check_bit("halted", halted, 1'b1); // still set long after the halt
    endtask

    task automatic error_response();
        prog.delete();
        prog.push_back(encode(op_store, sz_word, 12'h010, 16'h4321));
        prog.push_back(encode(op_load, sz_word, 12'hf04, 16'h0)); // error window
        prog.push_back(encode(op_store, sz_half, 12'h022, 16'h5a5a));
        prog.push_back(encode(op_load, sz_word, 12'h020, 16'h0));
        run_program(1'b0, 1'b1);
    endtask

    initial begin
        void'($urandom(32'h1aa8));
        reset      = 1'b1;
        load_ready = 1'b0;
        word_store_load();
        sizes_and_lanes();
        back_pressure();
        halt_stops_fetch();
        error_response();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
mem_pkg.sv
fetch_unit.sv
inst_decoder.sv
load_store_unit.sv
axi_bus_arbiter.sv
mem_sys_top.sv
axi_mem_model.sv
mem_sys_assert.sv
tb_mem_sys.sv
